// ==== src.f ====
src/calc_pkg.sv
src/operand_entry.sv
src/add_sub_unit.sv
src/shift_add_multiplier.sv
src/calc_control.sv
src/calculator_top.sv
tests/calculator_assertions.sv
tests/calculator_tb.sv

// ==== src/add_sub_unit.sv ====
module add_sub_unit #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             start,
    input  logic             sub,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] result,
    output logic             done
);

    logic [WIDTH-1:0] sum_q;
    logic             pending;  // Result registered, done follows

    // Flag pipeline, done one cycle after start is sampled
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            pending <= 1'b0;
            done    <= 1'b0;
        end else begin
            pending <= start;
            done    <= pending;
        end
    end

    // Modulo 2**WIDTH, borrow is dropped
    always_ff @(posedge clk) begin
        if (start) begin
            sum_q <= sub ? (a - b) : (a + b);
        end
    end

    assign result = sum_q;

endmodule

// ==== src/calc_control.sv ====
module calc_control
    import calc_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  key_t             key,
    input  op_sel_t          op_sel,
    input  logic             equal,
    input  logic             add_done,
    input  logic [WIDTH-1:0] add_result,
    input  logic             mul_done,
    input  logic [WIDTH-1:0] mul_result,
    output entry_ctrl_t      entry,
    output logic             add_start,
    output logic             sub,
    output logic             mul_start,
    output logic [WIDTH-1:0] result,
    output logic             complete
);

    calc_state_t      state;
    calc_state_t      next_state;
    op_sel_t          op_q;         // Operator latched in ENTER_FIRST
    logic             in_entry;
    logic [WIDTH-1:0] display_q;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= ENTER_FIRST;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ENTER_FIRST: begin
                if (is_op(op_sel)) begin
                    next_state = ENTER_SECOND;
                end
            end
            ENTER_SECOND: begin
                if (equal) begin
                    next_state = LAUNCH;
                end
            end
            LAUNCH: begin
                next_state = WAIT_UNIT;
            end
            WAIT_UNIT: begin
                if (add_done || mul_done) begin
                    next_state = SHOW;
                end
            end
            SHOW: begin
                next_state = ENTER_FIRST;
            end
            default: begin
                next_state = ENTER_FIRST;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            op_q <= OP_ADD;
        end else if (state == ENTER_FIRST && is_op(op_sel)) begin
            op_q <= op_sel;
        end
    end

    // Accumulator control straight from the state
    assign in_entry     = (state == ENTER_FIRST) || (state == ENTER_SECOND);
    assign entry.accept = in_entry && is_digit(key);
    assign entry.second = (state == ENTER_SECOND);
    assign entry.clear  = (state == SHOW);     // Operands cleared on leaving SHOW

    // Single LAUNCH cycle gives a one-cycle start
    assign add_start = (state == LAUNCH) && (op_q == OP_ADD || op_q == OP_SUB);
    assign mul_start = (state == LAUNCH) && (op_q == OP_MUL);
    assign sub       = (op_q == OP_SUB);

    // Display register, held until the next result
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            display_q <= '0;
        end else if (state == WAIT_UNIT) begin
            if (add_done) begin
                display_q <= add_result;
            end else if (mul_done) begin
                display_q <= mul_result;
            end
        end
    end

    assign result   = display_q;
    assign complete = (state == SHOW);

endmodule

// ==== src/calc_pkg.sv ====
package calc_pkg;

    // Keypad code, one per cycle
    typedef logic [3:0] key_t;

    localparam key_t KEY_NONE = 4'd0;   // No key pressed
    localparam key_t KEY_ZERO = 4'd10;  // Digit zero

    // One-hot operator level
    typedef logic [2:0] op_sel_t;

    localparam op_sel_t OP_ADD = 3'b001;
    localparam op_sel_t OP_SUB = 3'b010;
    localparam op_sel_t OP_MUL = 3'b100;

    typedef enum logic [2:0] {
        ENTER_FIRST  = 3'd0,    // Collecting operand A
        ENTER_SECOND = 3'd1,    // Collecting operand B
        LAUNCH       = 3'd2,    // Start pulse to chosen unit
        WAIT_UNIT    = 3'd3,    // Waiting for done
        SHOW         = 3'd4     // Complete cycle
    } calc_state_t;

    // Control bundle to the digit accumulator
    typedef struct packed {
        logic accept;   // Take digit this cycle
        logic second;   // 1 selects operand B
        logic clear;    // Zero both operands
    } entry_ctrl_t;

    // Codes 1 to 10 carry a digit
    function automatic logic is_digit(input key_t key);
        return (key != KEY_NONE) && (key <= KEY_ZERO);
    endfunction

    function automatic logic [3:0] digit_value(input key_t key);
        return (key == KEY_ZERO) ? 4'd0 : key;
    endfunction

    function automatic logic is_op(input op_sel_t op);
        return (op == OP_ADD) || (op == OP_SUB) || (op == OP_MUL);
    endfunction

endpackage

// ==== src/calculator_top.sv ====
module calculator_top
    import calc_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  key_t             key,
    input  op_sel_t          op_sel,
    input  logic             equal,
    output logic [WIDTH-1:0] result,
    output logic             complete
);

    entry_ctrl_t      entry;
    logic [WIDTH-1:0] operand_a;
    logic [WIDTH-1:0] operand_b;
    logic             add_start;
    logic             sub;
    logic             add_done;
    logic [WIDTH-1:0] add_result;
    logic             mul_start;
    logic             mul_done;
    logic [WIDTH-1:0] mul_result;

    calc_control #(.WIDTH(WIDTH)) u_control (
        .clk        (clk),
        .nRST       (nRST),
        .key        (key),
        .op_sel     (op_sel),
        .equal      (equal),
        .add_done   (add_done),
        .add_result (add_result),
        .mul_done   (mul_done),
        .mul_result (mul_result),
        .entry      (entry),
        .add_start  (add_start),
        .sub        (sub),
        .mul_start  (mul_start),
        .result     (result),
        .complete   (complete)
    );

    operand_entry #(.WIDTH(WIDTH)) u_entry (
        .clk       (clk),
        .nRST      (nRST),
        .entry     (entry),
        .key       (key),
        .operand_a (operand_a),
        .operand_b (operand_b)
    );

    // Both units see the same operand pair
    add_sub_unit #(.WIDTH(WIDTH)) u_add_sub (
        .clk    (clk),
        .nRST   (nRST),
        .start  (add_start),
        .sub    (sub),
        .a      (operand_a),
        .b      (operand_b),
        .result (add_result),
        .done   (add_done)
    );

    shift_add_multiplier #(.WIDTH(WIDTH)) u_mul (
        .clk    (clk),
        .nRST   (nRST),
        .start  (mul_start),
        .a      (operand_a),
        .b      (operand_b),
        .result (mul_result),
        .done   (mul_done)
    );

endmodule

// ==== src/operand_entry.sv ====
module operand_entry
    import calc_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  entry_ctrl_t      entry,
    input  key_t             key,
    output logic [WIDTH-1:0] operand_a,
    output logic [WIDTH-1:0] operand_b
);

    logic [WIDTH-1:0] reg_a;
    logic [WIDTH-1:0] reg_b;
    logic [WIDTH-1:0] selected;     // Operand being extended
    logic [WIDTH-1:0] digit;        // Key value at full width
    logic [WIDTH-1:0] next_value;   // selected*10 + digit

    assign selected = entry.second ? reg_b : reg_a;
    assign digit    = WIDTH'(digit_value(key));

    // Times ten as x*8 + x*2, wraps at WIDTH bits
    assign next_value = (selected << 3) + (selected << 1) + digit;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            reg_a <= '0;
            reg_b <= '0;
        end else if (entry.clear) begin
            reg_a <= '0;
            reg_b <= '0;
        end else if (entry.accept) begin
            if (entry.second) begin
                reg_b <= next_value;
            end else begin
                reg_a <= next_value;
            end
        end
    end

    assign operand_a = reg_a;
    assign operand_b = reg_b;

endmodule

// ==== src/shift_add_multiplier.sv ====
module shift_add_multiplier #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             start,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] result,
    output logic             done
);

    localparam int CNT_W = $clog2(WIDTH + 1);

    logic [CNT_W-1:0] count;    // Iterations left
    logic             busy;
    logic [WIDTH-1:0] mcand;    // Shifted left each cycle
    logic [WIDTH-1:0] mplier;   // Shifted right each cycle
    logic [WIDTH-1:0] acc;      // Low half of the product
    logic [WIDTH-1:0] addend;

    assign addend = mplier[0] ? mcand : '0;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= CNT_W'(WIDTH);
            end else if (busy) begin
                count <= count - 1'b1;
                // Last iteration lands together with done
                if (count == CNT_W'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // One multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc + addend;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Accumulator holds still once busy drops
    assign result = acc;

endmodule

// ==== tests/calculator_assertions.sv ====
module calculator_assertions (
    input logic clk,
    input logic nRST,
    input logic add_start,
    input logic mul_start,
    input logic complete
);

    int error_count = 0;    // Read by the testbench at the end

    // Only one unit is launched per calculation
    one_unit_started: assert property (@(posedge clk) disable iff (!nRST)
        !(add_start && mul_start))
    else begin
        $error("add_start and mul_start high together");
        error_count++;
    end

    add_start_pulse: assert property (@(posedge clk) disable iff (!nRST)
        add_start |=> !add_start)
    else begin
        $error("add_start longer than one cycle");
        error_count++;
    end

    mul_start_pulse: assert property (@(posedge clk) disable iff (!nRST)
        mul_start |=> !mul_start)
    else begin
        $error("mul_start longer than one cycle");
        error_count++;
    end

    complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
    else begin
        $error("complete longer than one cycle");
        error_count++;
    end

    // Held low through reset
    complete_in_reset: assert property (@(posedge clk) !nRST |-> !complete)
    else begin
        $error("complete high during reset");
        error_count++;
    end

endmodule

bind calc_control calculator_assertions u_assertions (
    .clk       (clk),
    .nRST      (nRST),
    .add_start (add_start),
    .mul_start (mul_start),
    .complete  (complete)
);

// ==== tests/calculator_tb.sv ====
module calculator_tb
    import calc_pkg::*;
;

    localparam int WIDTH = 16;

    logic             clk;
    logic             nRST;
    key_t             key;
    op_sel_t          op_sel;
    logic             equal;
    logic [WIDTH-1:0] result;
    logic             complete;

    calculator_top #(.WIDTH(WIDTH)) dut_i (
        .clk      (clk),
        .nRST     (nRST),
        .key      (key),
        .op_sel   (op_sel),
        .equal    (equal),
        .result   (result),
        .complete (complete)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Move to 1 time unit past the next rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("error: time %0t %s got %0d expected %0d",
                                     $time, name, got, expected));
        end
    endtask

    // Decimal string into wrapped operand as the keypad builds it
    function automatic logic [WIDTH-1:0] entry_value(input string digits);
        logic [WIDTH-1:0] value;
        value = '0;
        for (int i = 0; i < digits.len(); i++) begin
            value = value * 10 + (digits[i] - 8'h30);   // ASCII to digit
        end
        return value;
    endfunction

    function automatic logic [WIDTH-1:0] reference_result(input logic [WIDTH-1:0] a,
                                                          input logic [WIDTH-1:0] b,
                                                          input op_sel_t op);
        logic [2*WIDTH-1:0] product;
        product = a * b;
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;      // Borrow dropped
            default: return product[WIDTH-1:0];
        endcase
    endfunction

    task automatic press_key(input key_t code);
        key = code;
        step();
        key = KEY_NONE;
    endtask

    task automatic press_digits(input string digits);
        logic [7:0] d;
        for (int i = 0; i < digits.len(); i++) begin
            d = digits[i] - 8'h30;
            key = (d == 0) ? KEY_ZERO : key_t'(d);
            step();
        end
        key = KEY_NONE;
    endtask

    task automatic set_op(input op_sel_t op);
        op_sel = op;
        step();
        op_sel = '0;    // Released so the next calculation is not latched early
    endtask

    task automatic press_equal();
        equal = 1'b1;
        step();
        equal = 1'b0;
    endtask

    // Counts edges after the equal edge until complete is seen
    task automatic wait_complete(output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
            step();
            cycles++;
            if (complete) begin
                seen = 1'b1;
            end else if (cycles > WIDTH + 10) begin
                report_failure($sformatf("timeout: complete did not rise within %0d cycles",
                                         WIDTH + 10));
            end
        end
    endtask

    task automatic run_calc(input string a_str, input op_sel_t op, input string b_str);
        logic [WIDTH-1:0] expected;
        int               latency;
        expected = reference_result(entry_value(a_str), entry_value(b_str), op);
        press_digits(a_str);
        set_op(op);
        press_digits(b_str);
        press_equal();
        wait_complete(latency);
        check_value("latency", latency, (op == OP_MUL) ? WIDTH + 2 : 3);
        check_value("result", result, expected);
        step();     // SHOW left and operands cleared
        check_value("complete", complete, 1'b0);
        check_value("result", result, expected);
    endtask

    task automatic check_reset_state();
        check_value("result", result, '0);
        check_value("complete", complete, 1'b0);
    endtask

    task automatic add_multi_digit();
        run_calc("105", OP_ADD, "20");
        run_calc("9", OP_ADD, "1000");
    endtask

    task automatic subtract_with_wrap();
        run_calc("500", OP_SUB, "123");
        run_calc("37", OP_SUB, "52");   // Below zero
    endtask

    task automatic multiply_with_wrap();
        run_calc("300", OP_MUL, "400");
        run_calc("12", OP_MUL, "0");
    endtask

    task automatic ignore_stray_inputs();
        logic [WIDTH-1:0] expected;
        int               latency;
        expected = reference_result(entry_value("42"), entry_value("6"), OP_SUB);
        press_digits("4");
        for (int code = 11; code <= 15; code++) begin
            press_key(key_t'(code));
        end
        op_sel = 3'b011;    // Not one-hot
        step();
        op_sel = '0;
        press_digits("2");
        set_op(OP_SUB);
        press_key(4'd13);
        press_digits("6");
        press_equal();
        key    = 4'd9;      // Noise held while the unit runs
        op_sel = OP_MUL;
        equal  = 1'b1;
        wait_complete(latency);
        key    = KEY_NONE;
        op_sel = '0;
        equal  = 1'b0;
        check_value("latency", latency, 3);
        check_value("result", result, expected);
        repeat (3) step();
        check_value("complete", complete, 1'b0);
        check_value("result", result, expected);
        press_equal();      // Outside ENTER_SECOND
        for (int i = 0; i < 4; i++) begin
            step();
            check_value("complete", complete, 1'b0);
            check_value("result", result, expected);
        end
    endtask

    function automatic string random_operand();
        string s;
        int    n;
        s = "";
        n = 1 + ($urandom % 7);     // Long ones overflow during entry
        for (int i = 0; i < n; i++) begin
            s = {s, $sformatf("%0d", $urandom % 10)};
        end
        return s;
    endfunction

    task automatic run_random_calcs();
        op_sel_t ops[3];
        ops[0] = OP_ADD;
        ops[1] = OP_SUB;
        ops[2] = OP_MUL;
        for (int i = 0; i < 10; i++) begin
            run_calc(random_operand(), ops[$urandom % 3], random_operand());
        end
    endtask

    initial begin
        nRST   = 1'b0;
        key    = KEY_NONE;
        op_sel = '0;
        equal  = 1'b0;
        void'($urandom(32'h41a4266a));
        repeat (16) @(posedge clk);
        #1;
        nRST = 1'b1;
        check_reset_state();
        add_multi_digit();
        subtract_with_wrap();
        multiply_with_wrap();
        ignore_stray_inputs();
        run_random_calcs();
        step();
        if (dut_i.u_control.u_assertions.error_count != 0) begin
            $display("assertion failures: %0d", dut_i.u_control.u_assertions.error_count);
            $display("TESTBENCH FAILED");
            $fatal(1, "run stopped");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule
